// File: src/pmpChecker_settings.svh
// sizing for the PMP checker; PMP_ENTRIES must stay within 1..16 so an index fits PMP_IDX_BITS
`default_nettype none

`ifndef PMP_CHECKER_SETTINGS_SVH
`define PMP_CHECKER_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// address and entry sizing
////////////////////////////////////////////////////////////////////////////

// physical address width in bits, address registers hold bits [PA-1:2]
`define PMP_PA_BITS 34

// number of PMP entries in the register file and decoder row
`define PMP_ENTRIES 8

// width of an entry index carried in a request and in the response
`define PMP_IDX_BITS 4

`endif

`default_nettype wire

// File: src/pmpPkg.sv
// shared PMP types; the reserved cfg bits are stored as written and carry no meaning here
`include "pmpChecker_settings.svh"
`default_nettype none

package pmpPkg;

  // address matching mode, encoding as in the privileged spec
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmpAdrModeE;

  // kind of access being checked
  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1,
    EXEC  = 2'd2
  } pmpAccessE;

  // request opcodes on the four-phase port
  typedef enum logic [1:0] {
    CHECK = 2'd0,
    WRCFG = 2'd1,
    WRADR = 2'd2
  } pmpOpE;

  // one entry's 8-bit configuration, top bit first
  typedef struct packed {
    logic       lock;
    logic [1:0] rsvd;
    pmpAdrModeE mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmpCfgT;

  // one request; wdata is an address register value or a cfg byte in bits [7:0]
  typedef struct packed {
    pmpOpE                    op;
    logic [`PMP_IDX_BITS-1:0] index;
    logic [`PMP_PA_BITS-3:0]  wdata;
    logic [`PMP_PA_BITS-1:0]  addr;
    pmpAccessE                access;
    logic                     machine;
  } pmpReqT;

  // result of one address decoder
  typedef struct packed {
    logic match;
    logic lock;
    logic exec;
    logic write;
    logic read;
  } pmpEntryResT;

  // answer sent back with ack
  typedef struct packed {
    logic                     allowed;
    logic                     matched;
    logic [`PMP_IDX_BITS-1:0] matchIdx;
  } pmpRespT;

endpackage

`default_nettype wire

// File: src/pmpCsrFile.sv
// PMP cfg and address registers; only reset clears a lock, out-of-range indices are dropped
`timescale 1ns/1ns
`include "pmpChecker_settings.svh"
`default_nettype none

module pmpCsrFile import pmpPkg::*; (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       wrEn,
  input  pmpOpE                                      op,
  input  logic [`PMP_IDX_BITS-1:0]                   index,
  input  logic [`PMP_PA_BITS-3:0]                    wdata,
  output pmpCfgT [`PMP_ENTRIES-1:0]                  cfg,
  output logic   [`PMP_ENTRIES-1:0][`PMP_PA_BITS-3:0] adr
);

  // per-entry decode of the incoming write
  logic [`PMP_ENTRIES-1:0] hit;
  logic [`PMP_ENTRIES-1:0] nextTorLock;
  logic [`PMP_ENTRIES-1:0] cfgWe;
  logic [`PMP_ENTRIES-1:0] adrWe;

  ////////////////////////////////////////////////////////////////////////////
  // write enables with lock rules
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gWe
    // entry selected by the strobed index
    assign hit[i] = wrEn && (index == `PMP_IDX_BITS'(i));

    // a locked TOR entry above also freezes this entry's address,
    // since it forms the bottom of that locked range
    if (i < `PMP_ENTRIES - 1) begin : gNext
      assign nextTorLock[i] = cfg[i+1].lock && (cfg[i+1].mode == TOR);
    end else begin : gLast
      // last entry has nobody above it
      assign nextTorLock[i] = 1'b0;
    end

    // own lock blocks both kinds of write
    assign cfgWe[i] = hit[i] && (op == WRCFG) && !cfg[i].lock;
    assign adrWe[i] = hit[i] && (op == WRADR) && !cfg[i].lock && !nextTorLock[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // register storage
  ////////////////////////////////////////////////////////////////////////////

  // all entries come out of reset OFF with no permissions and a zero address
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
      adr <= '0;
    end else begin
      for (int i = 0; i < `PMP_ENTRIES; i++) begin
        // cfg byte lives in the low bits of wdata
        if (cfgWe[i]) begin
          cfg[i] <= pmpCfgT'(wdata[7:0]);
        end
        // address register takes the full word
        if (adrWe[i]) begin
          adr[i] <= wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pmpAdrDec.sv
// one PMP entry decoder; the access size is not checked, a straddling access is judged by its first byte
`timescale 1ns/1ns
`include "pmpChecker_settings.svh"
`default_nettype none

module pmpAdrDec import pmpPkg::*; (
  input  logic [`PMP_PA_BITS-1:0] addr,
  input  pmpCfgT                  cfg,
  input  logic [`PMP_PA_BITS-3:0] adr,
  input  logic                    geIn,
  output logic                    geOut,
  output pmpEntryResT             res
);

  logic [`PMP_PA_BITS-1:0] adrFull;
  logic                    addrLt;
  logic                    torMatch;
  logic [`PMP_PA_BITS-3:0] napotMask;
  logic [`PMP_PA_BITS-1:0] naMask;
  logic                    naMatch;
  logic                    match;

  ////////////////////////////////////////////////////////////////////////////
  // top of range
  ////////////////////////////////////////////////////////////////////////////

  // register holds byte address bits [PA-1:2]
  assign adrFull = {adr, 2'b00};

  // unsigned compare against this entry's bound
  assign addrLt = addr < adrFull;

  // handed up the chain as the lower bound of the next entry
  assign geOut = !addrLt;

  // between the previous bound (inclusive) and ours (exclusive)
  assign torMatch = geIn && addrLt;

  ////////////////////////////////////////////////////////////////////////////
  // naturally aligned regions
  ////////////////////////////////////////////////////////////////////////////

  // t trailing ones give a run of t+1 ones here
  assign napotMask = adr ^ (adr + 1'b1);

  // NA4 keeps only the byte offset, NAPOT widens it to 2^(t+3) bytes
  assign naMask = {(cfg.mode == NAPOT) ? napotMask : '0, 2'b11};

  // upper bits outside the mask must agree with the register
  assign naMatch = ((addr ^ adrFull) & ~naMask) == '0;

  // mode select, OFF never matches
  always_comb begin
    case (cfg.mode)
      TOR:        match = torMatch;
      NA4, NAPOT: match = naMatch;
      default:    match = 1'b0;
    endcase
  end

  // lock and permission bits pass straight through
  assign res.match = match;
  assign res.lock  = cfg.lock;
  assign res.exec  = cfg.exec;
  assign res.write = cfg.write;
  assign res.read  = cfg.read;

endmodule

`default_nettype wire

// File: src/pmpPrioritySel.sv
// PMP priority selector; lowest matching index wins, machine mode bypasses unlocked entries
`timescale 1ns/1ns
`include "pmpChecker_settings.svh"
`default_nettype none

module pmpPrioritySel import pmpPkg::*; (
  input  pmpEntryResT [`PMP_ENTRIES-1:0] ent,
  input  pmpAccessE                      access,
  input  logic                           machine,
  output pmpRespT                        resp
);

  // winning entry and its index
  pmpEntryResT              selEnt;
  logic                     anyMatch;
  logic [`PMP_IDX_BITS-1:0] selIdx;
  logic                     permit;

  // scan from the top down so the lowest match is the last one written
  always_comb begin
    selEnt   = '0;
    anyMatch = 1'b0;
    selIdx   = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (ent[i].match) begin
        selEnt   = ent[i];
        anyMatch = 1'b1;
        selIdx   = i[`PMP_IDX_BITS-1:0];
      end
    end
  end

  // pick the permission bit for this access type
  always_comb begin
    case (access)
      READ:    permit = selEnt.read;
      WRITE:   permit = selEnt.write;
      EXEC:    permit = selEnt.exec;
      default: permit = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // final decision
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    resp.matched  = anyMatch;
    resp.matchIdx = selIdx;
    if (!anyMatch) begin
      // no entry: machine passes, user is denied
      resp.allowed = machine;
    end else if (machine && !selEnt.lock) begin
      // unlocked entries do not restrict machine mode
      resp.allowed = 1'b1;
    end else begin
      resp.allowed = permit;
    end
  end

endmodule

`default_nettype wire

// File: src/pmpChecker.sv
// PMP checker top; one request in flight over a four-phase req/ack port, writes answer with all zeros
`timescale 1ns/1ns
`include "pmpChecker_settings.svh"
`default_nettype none

module pmpChecker import pmpPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    req,
  input  pmpReqT  reqData,
  output logic    ack,
  output pmpRespT resp
);

  // handshake states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } stateE;

  stateE state;

  // accepted request, held until the next one is taken
  pmpReqT reqQ;

  logic    isWrite;
  logic    wrStrobe;
  pmpRespT selResp;
  pmpRespT respQ;

  // register file outputs
  pmpCfgT [`PMP_ENTRIES-1:0]                  cfg;
  logic   [`PMP_ENTRIES-1:0][`PMP_PA_BITS-3:0] adr;

  // decoder row, chain bit i feeds entry i
  logic        [`PMP_ENTRIES:0]   geChain;
  pmpEntryResT [`PMP_ENTRIES-1:0] entRes;

  ////////////////////////////////////////////////////////////////////////////
  // four-phase handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  // IDLE takes req, BUSY evaluates for one cycle, DONE holds ack until req drops
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      respQ <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= BUSY;
          end
        end
        BUSY: begin
          state <= DONE;
          // writes never report a match or a grant
          respQ <= isWrite ? '0 : selResp;
        end
        DONE: begin
          // back-pressure: stay here with resp frozen
          if (!req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request payload, captured as it is accepted
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      reqQ <= reqData;
    end
  end

  // ack is a decoded register bit, low in IDLE and BUSY
  assign ack  = (state == DONE);
  assign resp = respQ;

  // write opcodes strobe the register file during the BUSY cycle only
  assign isWrite  = (reqQ.op == WRCFG) || (reqQ.op == WRADR);
  assign wrStrobe = (state == BUSY) && isWrite;

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  pmpCsrFile csr0 (
    .clk   (clk),
    .rst   (rst),
    .wrEn  (wrStrobe),
    .op    (reqQ.op),
    .index (reqQ.index),
    .wdata (reqQ.wdata),
    .cfg   (cfg),
    .adr   (adr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // decoder row and selection
  ////////////////////////////////////////////////////////////////////////////

  // entry 0 has an implicit lower bound of address zero
  assign geChain[0] = 1'b1;

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gDec
    pmpAdrDec dec (
      .addr  (reqQ.addr),
      .cfg   (cfg[i]),
      .adr   (adr[i]),
      .geIn  (geChain[i]),
      .geOut (geChain[i+1]),
      .res   (entRes[i])
    );
  end

  // reads register contents before any same-cycle write lands
  pmpPrioritySel sel0 (
    .ent     (entRes),
    .access  (reqQ.access),
    .machine (reqQ.machine),
    .resp    (selResp)
  );

endmodule

`default_nettype wire

// File: testbench/pmpChecker_chk.sv
// handshake assertions bound into pmpChecker; they assume the requester keeps the four-phase rules
`timescale 1ns/1ns
`include "pmpChecker_settings.svh"
`default_nettype none

module pmpChecker_chk import pmpPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    req,
  input logic    ack,
  input pmpRespT resp
);

  // reset forces IDLE and the first free cycle reaches BUSY at most
  ackLowAfterRst: assert property (@(posedge clk) rst |=> !ack)
    else $error("ack high in the cycle after a reset cycle");
  ackLowAfterRst2: assert property (@(posedge clk) $past(rst) |=> !ack)
    else $error("ack high two cycles after a reset cycle");

  // ack only rises at an edge where req was seen high
  ackRiseWithReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else $error("ack rose without req");

  // ack drops one edge after req was seen low
  ackFallAfterReqLow: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  // response is frozen for the whole ack phase
  respStable: assert property (@(posedge clk) disable iff (rst) ack && $past(ack) |-> $stable(resp))
    else $error("resp changed while ack stayed high");

endmodule

`default_nettype wire

// File: testbench/pmpCheckerTb.sv
// PMP checker testbench; address registers stay small so regions overlap, reset every 100 requests
`timescale 1ns/1ns
`include "pmpChecker_settings.svh"
`default_nettype none

module pmpCheckerTb import pmpPkg::*; ();

  localparam int PA = `PMP_PA_BITS;
  localparam int AW = `PMP_PA_BITS - 2;
  localparam int IW = `PMP_IDX_BITS;
  localparam int NUM_TXN = 400;
  localparam int TXN_PER_RESET = 100;
  localparam int CYCLE_LIMIT = NUM_TXN * 10 + 100;

  logic    clk;
  logic    rst;
  logic    req;
  logic    ack;
  pmpReqT  reqData;
  pmpRespT resp;

  logic [15:0] lfsr;
  int          cycles = 0;

  // reference copy of the register file
  pmpCfgT        mCfg [`PMP_ENTRIES];
  logic [AW-1:0] mAdr [`PMP_ENTRIES];

  pmpChecker dut0 (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .reqData (reqData),
    .ack     (ack),
    .resp    (resp)
  );

  bind pmpChecker pmpChecker_chk chk0 (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .ack  (ack),
    .resp (resp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit, sized from the transaction count
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and compare
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR, one step per bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void modelReset();
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      mCfg[i] = '0;
      mAdr[i] = '0;
    end
  endfunction

  // lock rules: own lock blocks both writes, a locked TOR entry above blocks the address
  function automatic void modelWrite(input pmpReqT r);
    int   i;
    logic aboveTorLock;
    i = int'(r.index);
    aboveTorLock = 1'b0;
    if (i >= `PMP_ENTRIES) begin
      return;
    end
    if (i < `PMP_ENTRIES - 1) begin
      aboveTorLock = mCfg[i+1].lock && (mCfg[i+1].mode == TOR);
    end
    if (r.op == WRCFG && !mCfg[i].lock) begin
      mCfg[i] = pmpCfgT'(r.wdata[7:0]);
    end
    if (r.op == WRADR && !mCfg[i].lock && !aboveTorLock) begin
      mAdr[i] = r.wdata;
    end
  endfunction

  // region bounds as byte ranges, first matching entry decides
  function automatic pmpRespT modelCheck(input pmpReqT r);
    pmpRespT         e;
    longint unsigned a;
    longint unsigned lo;
    longint unsigned hi;
    longint unsigned base;
    longint unsigned size;
    int              t;
    logic            hit;
    logic            perm;
    e = '0;
    a = 64'(r.addr);
    lo = 64'd0;
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      hi = 64'({mAdr[i], 2'b00});
      // t trailing ones give 2^(t+3) bytes
      t = 0;
      while (t < AW && mAdr[i][t]) begin
        t++;
      end
      size = 64'd1 << (t + 3);
      base = hi & ~(size - 64'd1);
      case (mCfg[i].mode)
        TOR:     hit = (a >= lo) && (a < hi);
        NA4:     hit = (a >= hi) && (a < hi + 64'd4);
        NAPOT:   hit = (a >= base) && (a < base + size);
        default: hit = 1'b0;
      endcase
      case (r.access)
        READ:    perm = mCfg[i].read;
        WRITE:   perm = mCfg[i].write;
        EXEC:    perm = mCfg[i].exec;
        default: perm = 1'b0;
      endcase
      if (hit && !e.matched) begin
        e.matched = 1'b1;
        e.matchIdx = IW'(i);
        e.allowed = (r.machine && !mCfg[i].lock) ? 1'b1 : perm;
      end
      lo = hi;
    end
    if (!e.matched) begin
      e.allowed = r.machine;
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and handshake
  ////////////////////////////////////////////////////////////////////////////

  // mostly checks, addresses aimed at the current region edges
  function automatic pmpReqT makeReq();
    pmpReqT        r;
    pmpCfgT        c;
    logic [2:0]    kind;
    logic [2:0]    k;
    logic [AW-1:0] mask;
    int            j;
    r = '0;
    kind = 3'(randBits(3));
    r.index = (randBits(1) == 32'd1) ? IW'(randBits(3)) : IW'(randBits(4));
    if (kind < 3'd5) begin
      r.op = CHECK;
    end else if (kind == 3'd5) begin
      r.op = WRCFG;
    end else begin
      r.op = WRADR;
    end
    // locks are kept rare so the row stays writable between resets
    c.lock = (randBits(3) == 32'd0);
    c.rsvd = 2'(randBits(2));
    c.mode = pmpAdrModeE'(2'(randBits(2)));
    {c.exec, c.write, c.read} = 3'(randBits(3));
    if (r.op == WRCFG) begin
      r.wdata = AW'(c);
    end else if (r.op == WRADR) begin
      r.wdata = (randBits(3) == 32'd0) ? AW'(randBits(32)) : AW'(randBits(8));
    end
    r.access = pmpAccessE'(2'(randBits(2) % 32'd3));
    r.machine = (randBits(1) == 32'd1);
    j = int'(randBits(3)) % `PMP_ENTRIES;
    k = 3'(randBits(3));
    mask = (AW'(1) << k) - AW'(1);
    case (2'(randBits(2)))
      2'd0: r.addr = {mAdr[j], 2'b00} + PA'(randBits(4)) - PA'(8);
      2'd1: begin
        // just outside or inside an aligned block around the register
        if (randBits(1) == 32'd1) begin
          r.addr = {mAdr[j] & ~mask, 2'b00} - PA'(randBits(1));
        end else begin
          r.addr = {mAdr[j] | mask, 2'b11} + PA'(randBits(1));
        end
      end
      2'd2: r.addr = PA'(randBits(10));
      default: r.addr = PA'({randBits(32), randBits(32)});
    endcase
    return r;
  endfunction

  // one four-phase transfer, entered and left on a falling edge with ack low
  task automatic runTxn(input pmpReqT r, input pmpRespT exp);
    pmpRespT held;
    int      extra;
    reqData = r;
    req = 1'b1;
    @(negedge clk);
    while (!ack) begin
      @(negedge clk);
    end
    held = resp;
    checkEq(64'(resp), 64'(exp), "resp when ack rose");
    // back-pressure hold
    extra = int'(randBits(2));
    repeat (extra) begin
      @(negedge clk);
      checkEq(64'(ack), 64'd1, "ack under back-pressure");
      checkEq(64'(resp), 64'(held), "resp under back-pressure");
    end
    req = 1'b0;
    @(negedge clk);
    checkEq(64'(ack), 64'd0, "ack one cycle after req dropped");
  endtask

  initial begin
    pmpReqT  r;
    pmpRespT expResp;
    lfsr = 16'd9;
    rst = 1'b1;
    req = 1'b0;
    reqData = '0;
    modelReset();
    for (int n = 0; n < NUM_TXN; n++) begin
      // a periodic reset is the only way locks get cleared
      if (n % TXN_PER_RESET == 0) begin
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        modelReset();
        checkEq(64'(ack), 64'd0, "ack after reset");
      end
      r = makeReq();
      expResp = (r.op == CHECK) ? modelCheck(r) : '0;
      runTxn(r, expResp);
      modelWrite(r);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/pmpPkg.sv
src/pmpCsrFile.sv
src/pmpAdrDec.sv
src/pmpPrioritySel.sv
src/pmpChecker.sv
testbench/pmpChecker_chk.sv
testbench/pmpCheckerTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the PMP checker testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module pmpCheckerTb -o simPmp

# the testbench decides pass or fail, the exit code of the run is not trusted alone
output=$(./obj_dir/simPmp 2>&1) || true
echo "$output"

if echo "$output" | grep -qxF '>>> PASS'; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
